/* hw/user_proj_consts.svh */
// ----------------------------------------------------------
// User project constants
// Bus widths, region codes, register map and wait counts
// ----------------------------------------------------------
`ifndef USER_PROJ_CONSTS_SVH
`define USER_PROJ_CONSTS_SVH

// Bus widths
`define WB_DATA_W          32
`define LITE_ADDR_W        12

// Upper twelve address bits per region
`define REGION_SRAM        12'h380
`define REGION_FIR         12'h300

// Highest low-byte offset forwarded to AXI-Lite
`define LITE_LIMIT         8'h7F

// Scratch SRAM
`define SRAM_ACK_DELAY     10
`define SRAM_AW            8

// Bridge minimum latency count
`define BRIDGE_MIN_CYCLES  10

// Register target map
`define CTRL_OFS           12'h000
`define CTRL_W             3
`define TAP_BASE           12'h040
`define TAP_COUNT          16

`endif

/* hw/user_proj_pkg.sv */
// ----------------------------------------------------------
// User project package
// Bus word, AXI-Lite address, region and bridge state types
// ----------------------------------------------------------
`include "user_proj_consts.svh"

package user_proj_pkg;

    // One Wishbone or AXI-Lite data word
    typedef logic [`WB_DATA_W-1:0] word_t;

    // AXI-Lite byte address
    typedef logic [`LITE_ADDR_W-1:0] lite_addr_t;

    // Decoded target of a Wishbone access
    typedef enum logic [1:0] {
        REGION_NONE = 2'b00,
        REGION_SRAM = 2'b10,
        REGION_FIR  = 2'b11
    } region_e;

    // Bridge FSM states
    typedef enum logic [2:0] {
        LITE_IDLE  = 3'd0,
        LITE_WRITE = 3'd1,
        LITE_READ  = 3'd2,
        LITE_WAIT  = 3'd3,
        LITE_ACK   = 3'd4
    } lite_state_e;

endpackage

/* hw/wb_region_decode.sv */
// ----------------------------------------------------------
// Wishbone region decoder
// Routes strobe and cycle to the SRAM or the AXI-Lite bridge
// and returns the selected acknowledge and read data
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "user_proj_consts.svh"

module wb_region_decode (
    input  logic                 wbs_stb_i,
    input  logic                 wbs_cyc_i,
    input  user_proj_pkg::word_t wbs_adr_i,
    input  logic                 sram_ack_i,
    input  user_proj_pkg::word_t sram_dat_i,
    input  logic                 fir_ack_i,
    input  user_proj_pkg::word_t fir_dat_i,
    output logic                 sram_stb_o,
    output logic                 sram_cyc_o,
    output logic                 fir_stb_o,
    output logic                 fir_cyc_o,
    output logic                 wbs_ack_o,
    output user_proj_pkg::word_t wbs_dat_o
);

    user_proj_pkg::region_e region;

    // Upper twelve address bits pick the region
    always_comb begin
        case (wbs_adr_i[`WB_DATA_W-1 -: 12])
            `REGION_SRAM: region = user_proj_pkg::REGION_SRAM;
            `REGION_FIR:  region = user_proj_pkg::REGION_FIR;
            default:      region = user_proj_pkg::REGION_NONE;
        endcase
    end

    // Only the addressed region sees the strobe
    assign sram_stb_o = wbs_stb_i && (region == user_proj_pkg::REGION_SRAM);
    assign sram_cyc_o = wbs_cyc_i && (region == user_proj_pkg::REGION_SRAM);
    assign fir_stb_o  = wbs_stb_i && (region == user_proj_pkg::REGION_FIR);
    assign fir_cyc_o  = wbs_cyc_i && (region == user_proj_pkg::REGION_FIR);

    // Response mux, unmapped space never acks
    always_comb begin
        wbs_ack_o = 1'b0;
        wbs_dat_o = '0;
        if (region == user_proj_pkg::REGION_SRAM) begin
            wbs_ack_o = sram_ack_i;
            wbs_dat_o = sram_dat_i;
        end else if (region == user_proj_pkg::REGION_FIR) begin
            wbs_ack_o = fir_ack_i;
            wbs_dat_o = fir_dat_i;
        end
    end

endmodule

/* hw/wb_sram_port.sv */
// ----------------------------------------------------------
// Scratch SRAM Wishbone port
// 256 words with byte-lane writes, each access acknowledged
// after a fixed wait
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "user_proj_consts.svh"

module wb_sram_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stb_i,
    input  logic                 cyc_i,
    input  logic                 we_i,
    input  logic [3:0]           sel_i,
    input  user_proj_pkg::word_t adr_i,
    input  user_proj_pkg::word_t dat_i,
    output logic                 ack_o,
    output user_proj_pkg::word_t dat_o
);

    localparam int CNT_W = $clog2(`SRAM_ACK_DELAY + 1);

    user_proj_pkg::word_t mem [0:(1 << `SRAM_AW) - 1];

    logic [CNT_W-1:0]    wait_cnt;
    logic [`SRAM_AW-1:0] word_adr;
    logic                pending;
    logic                done;

    // Byte address in, word index out
    assign word_adr = adr_i[`SRAM_AW+1:2];

    // Pending until the ack pulse goes out
    assign pending = stb_i && cyc_i && !ack_o;
    assign done    = pending && (wait_cnt == CNT_W'(`SRAM_ACK_DELAY));

    // Wait counter and one-cycle ack
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_o    <= 1'b0;
            wait_cnt <= '0;
        end else begin
            ack_o <= done;
            if (done) begin
                wait_cnt <= '0;
            end else if (pending) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // Storage, writes land together with the ack
    always_ff @(posedge clk) begin
        if (done) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i && sel_i[b]) begin
                    mem[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
            // Old word, valid while ack is high
            dat_o <= mem[word_adr];
        end
    end

endmodule

/* hw/wb_axil_bridge.sv */
// ----------------------------------------------------------
// Wishbone to AXI-Lite bridge
// Turns each Wishbone access into one AXI-Lite write or read
// and holds the ack off for a minimum cycle count
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "user_proj_consts.svh"

module wb_axil_bridge (
    input  logic                      clk,
    input  logic                      rst,
    // Wishbone side
    input  logic                      stb_i,
    input  logic                      cyc_i,
    input  logic                      we_i,
    input  user_proj_pkg::word_t      adr_i,
    input  user_proj_pkg::word_t      dat_i,
    output logic                      ack_o,
    output user_proj_pkg::word_t      dat_o,
    // AXI-Lite write channels
    output logic                      awvalid_o,
    output user_proj_pkg::lite_addr_t awaddr_o,
    output logic                      wvalid_o,
    output user_proj_pkg::word_t      wdata_o,
    input  logic                      awready_i,
    input  logic                      wready_i,
    // AXI-Lite read channels
    output logic                      arvalid_o,
    output user_proj_pkg::lite_addr_t araddr_o,
    input  logic                      arready_i,
    input  logic                      rvalid_i,
    input  user_proj_pkg::word_t      rdata_i,
    output logic                      rready_o
);

    localparam int CNT_W = $clog2(`BRIDGE_MIN_CYCLES + 1);

    user_proj_pkg::lite_state_e state;
    user_proj_pkg::lite_addr_t  lite_adr;

    logic [CNT_W-1:0] lat_cnt;
    logic             access;
    logic             r_fire;

    // Only low offsets up to the limit go out on AXI-Lite
    assign access = stb_i && cyc_i && (adr_i[7:0] <= `LITE_LIMIT);
    assign r_fire = rvalid_i && rready_o;

    // One captured address serves both channels
    assign awaddr_o = lite_adr;
    assign araddr_o = lite_adr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= user_proj_pkg::LITE_IDLE;
            ack_o     <= 1'b0;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            arvalid_o <= 1'b0;
            rready_o  <= 1'b0;
            lat_cnt   <= '0;
        end else begin
            // Counts every cycle after acceptance, stops at the minimum
            if (state != user_proj_pkg::LITE_IDLE &&
                lat_cnt < CNT_W'(`BRIDGE_MIN_CYCLES)) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
            case (state)
                user_proj_pkg::LITE_IDLE: begin
                    lat_cnt <= '0;
                    if (access && we_i) begin
                        awvalid_o <= 1'b1;
                        wvalid_o  <= 1'b1;
                        state     <= user_proj_pkg::LITE_WRITE;
                    end else if (access) begin
                        arvalid_o <= 1'b1;
                        state     <= user_proj_pkg::LITE_READ;
                    end
                end
                user_proj_pkg::LITE_WRITE: begin
                    // Address and data retire together
                    if (awvalid_o && wvalid_o && awready_i && wready_i) begin
                        awvalid_o <= 1'b0;
                        wvalid_o  <= 1'b0;
                        state     <= user_proj_pkg::LITE_WAIT;
                    end
                end
                user_proj_pkg::LITE_READ: begin
                    if (arvalid_o && arready_i) begin
                        arvalid_o <= 1'b0;
                        rready_o  <= 1'b1;
                    end
                    if (r_fire) begin
                        rready_o <= 1'b0;
                        state    <= user_proj_pkg::LITE_WAIT;
                    end
                end
                user_proj_pkg::LITE_WAIT: begin
                    // Hold off the ack until the floor is met
                    if (lat_cnt >= CNT_W'(`BRIDGE_MIN_CYCLES)) begin
                        ack_o <= 1'b1;
                        state <= user_proj_pkg::LITE_ACK;
                    end
                end
                user_proj_pkg::LITE_ACK: begin
                    ack_o <= 1'b0;
                    state <= user_proj_pkg::LITE_IDLE;
                end
                default: begin
                    state <= user_proj_pkg::LITE_IDLE;
                end
            endcase
        end
    end

    // Request payload captured at acceptance
    always_ff @(posedge clk) begin
        if (state == user_proj_pkg::LITE_IDLE && access) begin
            lite_adr <= adr_i[`LITE_ADDR_W-1:0];
            wdata_o  <= dat_i;
        end
    end

    // Read data kept from the R handshake through ack
    always_ff @(posedge clk) begin
        if (r_fire) begin
            dat_o <= rdata_i;
        end
    end

endmodule

/* hw/axil_tap_regs.sv */
// ----------------------------------------------------------
// AXI-Lite tap register target
// 3-bit control register and sixteen tap coefficient words
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "user_proj_consts.svh"

module axil_tap_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      awvalid_i,
    input  user_proj_pkg::lite_addr_t awaddr_i,
    input  logic                      wvalid_i,
    input  user_proj_pkg::word_t      wdata_i,
    input  logic                      arvalid_i,
    input  user_proj_pkg::lite_addr_t araddr_i,
    input  logic                      rready_i,
    output logic                      awready_o,
    output logic                      wready_o,
    output logic                      arready_o,
    output logic                      rvalid_o,
    output user_proj_pkg::word_t      rdata_o
);

    localparam int TAP_IW = $clog2(`TAP_COUNT);
    localparam user_proj_pkg::lite_addr_t TAP_END =
        user_proj_pkg::lite_addr_t'(`TAP_BASE + 4 * `TAP_COUNT);

    user_proj_pkg::word_t taps [0:`TAP_COUNT-1];
    user_proj_pkg::word_t rd_word;

    logic [`CTRL_W-1:0] ctrl_q;
    logic               wr_fire;
    logic               rd_fire;

    // Word-aligned offset inside the tap window
    function automatic logic tap_hit(input user_proj_pkg::lite_addr_t a);
        return (a >= `TAP_BASE) && (a < TAP_END) && (a[1:0] == 2'b00);
    endfunction

    assign wr_fire = awvalid_i && wvalid_i && awready_o && wready_o;
    assign rd_fire = arvalid_i && arready_o;

    // Handshakes and control register
    always_ff @(posedge clk) begin
        if (rst) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            ctrl_q    <= '0;
        end else begin
            // AW and W accepted together, one pulse
            awready_o <= awvalid_i && wvalid_i && !awready_o;
            wready_o  <= awvalid_i && wvalid_i && !awready_o;
            arready_o <= arvalid_i && !arready_o && !rvalid_o;
            if (rd_fire) begin
                rvalid_o <= 1'b1;
            end else if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
            // Upper write bits dropped
            if (wr_fire && awaddr_i == `CTRL_OFS) begin
                ctrl_q <= wdata_i[`CTRL_W-1:0];
            end
        end
    end

    // Tap index from low bits, base is window-aligned
    always_ff @(posedge clk) begin
        if (wr_fire && tap_hit(awaddr_i)) begin
            taps[awaddr_i[TAP_IW+1:2]] <= wdata_i;
        end
    end

    // Read mux, holes return zero
    always_comb begin
        rd_word = '0;
        if (araddr_i == `CTRL_OFS) begin
            rd_word[`CTRL_W-1:0] = ctrl_q;
        end else if (tap_hit(araddr_i)) begin
            rd_word = taps[araddr_i[TAP_IW+1:2]];
        end
    end

    // Held until rready
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_o <= rd_word;
        end
    end

endmodule

/* hw/user_proj_top.sv */
// ----------------------------------------------------------
// User project top level
// Wishbone slave split into scratch SRAM and an AXI-Lite
// bridge to the tap register target
// ----------------------------------------------------------
`timescale 1ns/1ps

module user_proj_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_we_i,
    input  logic [3:0]           wbs_sel_i,
    input  user_proj_pkg::word_t wbs_adr_i,
    input  user_proj_pkg::word_t wbs_dat_i,
    output logic                 wbs_ack_o,
    output user_proj_pkg::word_t wbs_dat_o
);

    // Gated Wishbone per region
    logic                 sram_stb;
    logic                 sram_cyc;
    logic                 sram_ack;
    user_proj_pkg::word_t sram_dat;
    logic                 fir_stb;
    logic                 fir_cyc;
    logic                 fir_ack;
    user_proj_pkg::word_t fir_dat;

    // AXI-Lite between bridge and target
    logic                      awvalid;
    logic                      awready;
    user_proj_pkg::lite_addr_t awaddr;
    logic                      wvalid;
    logic                      wready;
    user_proj_pkg::word_t      wdata;
    logic                      arvalid;
    logic                      arready;
    user_proj_pkg::lite_addr_t araddr;
    logic                      rvalid;
    logic                      rready;
    user_proj_pkg::word_t      rdata;

    wb_region_decode u_decode (
        .wbs_stb_i  (wbs_stb_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_adr_i  (wbs_adr_i),
        .sram_ack_i (sram_ack),
        .sram_dat_i (sram_dat),
        .fir_ack_i  (fir_ack),
        .fir_dat_i  (fir_dat),
        .sram_stb_o (sram_stb),
        .sram_cyc_o (sram_cyc),
        .fir_stb_o  (fir_stb),
        .fir_cyc_o  (fir_cyc),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o)
    );

    wb_sram_port u_sram (
        .clk   (clk),
        .rst   (rst),
        .stb_i (sram_stb),
        .cyc_i (sram_cyc),
        .we_i  (wbs_we_i),
        .sel_i (wbs_sel_i),
        .adr_i (wbs_adr_i),
        .dat_i (wbs_dat_i),
        .ack_o (sram_ack),
        .dat_o (sram_dat)
    );

    wb_axil_bridge u_bridge (
        .clk       (clk),
        .rst       (rst),
        .stb_i     (fir_stb),
        .cyc_i     (fir_cyc),
        .we_i      (wbs_we_i),
        .adr_i     (wbs_adr_i),
        .dat_i     (wbs_dat_i),
        .ack_o     (fir_ack),
        .dat_o     (fir_dat),
        .awvalid_o (awvalid),
        .awaddr_o  (awaddr),
        .wvalid_o  (wvalid),
        .wdata_o   (wdata),
        .awready_i (awready),
        .wready_i  (wready),
        .arvalid_o (arvalid),
        .araddr_o  (araddr),
        .arready_i (arready),
        .rvalid_i  (rvalid),
        .rdata_i   (rdata),
        .rready_o  (rready)
    );

    axil_tap_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .awvalid_i (awvalid),
        .awaddr_i  (awaddr),
        .wvalid_i  (wvalid),
        .wdata_i   (wdata),
        .arvalid_i (arvalid),
        .araddr_i  (araddr),
        .rready_i  (rready),
        .awready_o (awready),
        .wready_o  (wready),
        .arready_o (arready),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata)
    );

endmodule

/* bench/user_proj_asserts.sv */
// ----------------------------------------------------------
// Bridge handshake assertions
// AXI-Lite valid hold rules and the single-cycle Wishbone ack
// ----------------------------------------------------------
`timescale 1ns/1ps

module user_proj_asserts (
    input  logic clk_i,
    input  logic rst_i,
    input  logic awvalid_i,
    input  logic wvalid_i,
    input  logic awready_i,
    input  logic wready_i,
    input  logic arvalid_i,
    input  logic arready_i,
    input  logic ack_i
);

    // Number of assertion failures so far
    int fail_cnt = 0;

    // Write address held until AW and W retire together
    aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        awvalid_i && !(awready_i && wready_i) |=> awvalid_i && wvalid_i)
        else begin
            $error("awvalid dropped before its handshake");
            fail_cnt++;
        end

    // Read address held until arready
    ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        arvalid_i && !arready_i |=> arvalid_i)
        else begin
            $error("arvalid dropped before arready");
            fail_cnt++;
        end

    // Ack lasts one cycle
    ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |=> !ack_i)
        else begin
            $error("bridge ack held for more than one cycle");
            fail_cnt++;
        end

endmodule

bind wb_axil_bridge user_proj_asserts u_asserts (
    .clk_i     (clk),
    .rst_i     (rst),
    .awvalid_i (awvalid_o),
    .wvalid_i  (wvalid_o),
    .awready_i (awready_i),
    .wready_i  (wready_i),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .ack_i     (ack_o)
);

/* bench/tb_user_proj.sv */
// ----------------------------------------------------------
// User project testbench
// Wishbone master replaying a transaction file against the
// SRAM and the AXI-Lite tap registers, with latency checks
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "user_proj_consts.svh"

module tb_user_proj;

    logic                 clk;
    logic                 rst;
    logic                 wbs_stb_i;
    logic                 wbs_cyc_i;
    logic                 wbs_we_i;
    logic [3:0]           wbs_sel_i;
    user_proj_pkg::word_t wbs_adr_i;
    user_proj_pkg::word_t wbs_dat_i;
    logic                 wbs_ack_o;
    user_proj_pkg::word_t wbs_dat_o;

    // Transaction list, one entry per file line
    logic [31:0] t_we[$];
    logic [31:0] t_adr[$];
    logic [31:0] t_sel[$];
    logic [31:0] t_dat[$];
    logic [31:0] t_exp[$];

    integer seed = 57449;
    int     cycle_cnt = 0;
    int     cycle_limit = 1000;

    user_proj_top UUT (
        .clk       (clk),
        .rst       (rst),
        .wbs_stb_i (wbs_stb_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Columns: we, address, byte select, write data, expected read
    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [5];
        fd = $fopen("bench/user_proj_stim.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file bench/user_proj_stim.txt");
        end
        while ($fgets(line, fd) > 0) begin
            // Skip comments and blank lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
            if (n != 5) begin
                fail_run($sformatf("stimulus line has %0d fields instead of 5", n));
            end
            t_we.push_back(f[0]);
            t_adr.push_back(f[1]);
            t_sel.push_back(f[2]);
            t_dat.push_back(f[3]);
            t_exp.push_back(f[4]);
        end
        $fclose(fd);
    endtask

    // One Wishbone access, cycles counted from the launch edge to ack
    task automatic wb_access(input logic we_v, input logic [31:0] adr_v,
                             input logic [3:0] sel_v, input logic [31:0] dat_v,
                             output logic [31:0] rdat, output int cycles);
        @(posedge clk);
        wbs_stb_i <= 1'b1;
        wbs_cyc_i <= 1'b1;
        wbs_we_i  <= we_v;
        wbs_sel_i <= sel_v;
        wbs_adr_i <= adr_v;
        wbs_dat_i <= dat_v;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            // Outputs settled mid-cycle
            @(negedge clk);
        end while (wbs_ack_o !== 1'b1);
        rdat = wbs_dat_o;
        @(posedge clk);
        wbs_stb_i <= 1'b0;
        wbs_cyc_i <= 1'b0;
    endtask

    // Watchdog and bridge assertion monitor
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, transactions did not finish",
                               cycle_cnt));
        end else if (UUT.u_bridge.u_asserts.fail_cnt != 0) begin
            fail_run("a bridge handshake assertion fired");
        end
    end

    initial begin
        logic [31:0] rdat;
        int          cycles;
        int          gap;
        rst       = 1'b1;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'h0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        load_stim();
        cycle_limit = t_adr.size() * 40 + 100;
        repeat (3) @(posedge clk);
        rst       <= 1'b0;
        // Quiet bus after reset, address parked in each mapped region
        wbs_adr_i <= {`REGION_SRAM, 20'h00000};
        repeat (3) begin
            @(negedge clk);
            check_equal("wbs_ack_o", wbs_ack_o, 32'd0);
        end
        @(posedge clk);
        wbs_adr_i <= {`REGION_FIR, 20'h00000};
        repeat (3) begin
            @(negedge clk);
            check_equal("wbs_ack_o", wbs_ack_o, 32'd0);
        end
        for (int i = 0; i < t_adr.size(); i++) begin
            wb_access(t_we[i][0], t_adr[i], t_sel[i][3:0], t_dat[i], rdat, cycles);
            if (t_adr[i][31:20] == `REGION_SRAM) begin
                check_equal("sram ack latency", cycles, `SRAM_ACK_DELAY + 1);
            end else if (cycles < `BRIDGE_MIN_CYCLES + 2) begin
                fail_run($sformatf("bridge acknowledged after only %0d cycles", cycles));
            end
            if (!t_we[i][0]) begin
                check_equal("wbs_dat_o", rdat, t_exp[i]);
            end
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk);
        end
        if (UUT.u_bridge.u_asserts.fail_cnt != 0) begin
            fail_run("a bridge handshake assertion fired");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* bench/user_proj_stim.txt */
# we adr sel wdata expected (hex), we=1 write, we=0 read
# SRAM region 0x380, partial byte writes then full reads
1 38000000 f 11223344 00000000
1 38000000 2 aabbccdd 00000000
1 38000004 f 00000000 00000000
1 38000004 9 a1b2c3d4 00000000
1 38000008 f ffffffff 00000000
1 38000008 6 12345678 00000000
0 38000000 f 00000000 1122cc44
0 38000004 f 00000000 a10000d4
0 38000008 f 00000000 ff3456ff
# Bridge region 0x300, taps and control register
1 30000040 f 0000a001 00000000
1 3000007c f 0000a00f 00000000
1 30000044 f deadbeef 00000000
1 30000000 f deadbeef 00000000
0 30000040 f 00000000 0000a001
0 3000007c f 00000000 0000a00f
0 30000044 f 00000000 deadbeef
0 30000000 f 00000000 00000007
# Holes between control and taps
1 30000010 f 12345678 00000000
0 30000010 f 00000000 00000000
0 3000003c f 00000000 00000000
0 30000004 f 00000000 00000000
1 30000000 f 00000012 00000000
0 30000000 f 00000000 00000002

/* sim.f */
+incdir+hw
hw/user_proj_pkg.sv
hw/wb_region_decode.sv
hw/wb_sram_port.sv
hw/wb_axil_bridge.sv
hw/axil_tap_regs.sv
hw/user_proj_top.sv
bench/user_proj_asserts.sv
bench/tb_user_proj.sv

/* Bender.yml */
package:
  name: user_proj

sources:
  - include_dirs:
      - hw
    files:
      - hw/user_proj_pkg.sv
      - hw/wb_region_decode.sv
      - hw/wb_sram_port.sv
      - hw/wb_axil_bridge.sv
      - hw/axil_tap_regs.sv
      - hw/user_proj_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/user_proj_asserts.sv
      - bench/tb_user_proj.sv
